// File: project.f
rtl/tart_pkg.sv
rtl/ax_capture.sv
rtl/sample_fifo.sv
rtl/aq_unit.sv
rtl/rst_control.sv
rtl/bus_decode.sv
rtl/tart_core.sv
tests/tart_assertions.sv
tests/tart_tb.sv

// File: tests/tart_tb.sv
`default_nettype none
`timescale 1ns/1ns

module tart_tb import tart_pkg::*; ();

   localparam int ANTENNAE   = 8;
   localparam int FIFO_DEPTH = 16;
   localparam int RTIME      = 4;
   localparam int ACK_LIMIT  = 50;              // Cycles to wait for one ack
   localparam int POLL_LIMIT = 20;              // Status polls while sys_rst is high

   logic                b_clk = 1'b0;
   logic                arst_n;
   bus_req_t            bus_req;
   bus_rsp_t            bus_rsp;
   logic [ANTENNAE-1:0] antenna;
   logic                ax_stb;
   logic                led;

   logic [31:0] lcg_state = 32'h035d_10c5;
   word_t       exp_q [$];                      // Samples expected in the FIFO
   word_t       exp_sum;                        // Model of REG_AQ_SUM
   word_t       dbg_next;                       // Next debug counter value

   always #10 b_clk = ~b_clk;                   // 20 ns period

   tart_core #(
      .ANTENNAE   (ANTENNAE),
      .FIFO_DEPTH (FIFO_DEPTH),
      .RTIME      (RTIME)
   ) dut_i (
      .b_clk     (b_clk),
      .arst_n_i  (arst_n),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .antenna_i (antenna),
      .ax_stb_i  (ax_stb),
      .led_o     (led)
   );

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [ADR_BITS-1:0] aq_adr(input logic [2:0] off);
      return {AQ_BASE, off};
   endfunction

   function automatic logic [ADR_BITS-1:0] rst_adr(input logic [1:0] off);
      return {RST_BASE, off};
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic cmp_byte(input string name, input word_t got, input word_t want);
      if (got !== want) begin
         stop_run($sformatf("Mismatch at %0t ns: %s got 0x%02h, expected 0x%02h",
                            $time, name, got, want));
      end
   endtask

   // Expected byte built from the status fields
   task automatic cmp_status(input string name, input word_t got, input logic underrun,
                             input logic overflow, input logic empty, input int level);
      word_t want;
      want = {underrun, overflow, empty, 5'(level)};
      if (got !== want) begin
         stop_run($sformatf("Mismatch at %0t ns: %s got 0x%02h, expected 0x%02h",
                            $time, name, got, want));
      end
   endtask

   task automatic cmp_ctrl(input aq_ctrl_t got, input aq_ctrl_t want);
      if (got !== want) begin
         stop_run($sformatf("Mismatch at %0t ns: REG_AQ_CTRL got %b, expected %b",
                            $time, got, want));
      end
   endtask

   // ----------------------------------------
   // Bus and antenna drivers
   // ----------------------------------------
   task automatic bus_xfer(input logic we, input logic [ADR_BITS-1:0] adr,
                           input word_t wdat, output word_t rdat);
      int waited;
      @(negedge b_clk);
      bus_req.cyc = 1'b1;
      bus_req.stb = 1'b1;
      bus_req.we  = we;
      bus_req.adr = adr;
      bus_req.dat = wdat;
      waited = 0;
      do begin
         @(negedge b_clk);
         waited++;
         if (waited > ACK_LIMIT) begin
            stop_run($sformatf("Timeout: no bus ack for address 0x%02h", adr));
         end
      end while (!bus_rsp.ack);
      rdat = bus_rsp.dat;                       // Valid in the ack cycle
      @(negedge b_clk);                         // Stb held over the edge ending ack
      bus_req = '0;
   endtask

   task automatic bus_write(input logic [ADR_BITS-1:0] adr, input word_t wdat);
      word_t unused;
      bus_xfer(1'b1, adr, wdat, unused);
   endtask

   task automatic bus_read(input logic [ADR_BITS-1:0] adr, output word_t rdat);
      bus_xfer(1'b0, adr, '0, rdat);
   endtask

   // Poll REG_RST until the stretched reset is over
   task automatic wait_reset_done();
      word_t rd;
      int    polls;
      polls = 0;
      do begin
         bus_read(rst_adr(REG_RST), rd);
         polls++;
         if (polls > POLL_LIMIT) begin
            stop_run("Timeout: sys_rst stayed high");
         end
      end while (rd[0]);
   endtask

   task automatic set_ctrl(input logic enable, input logic debug, input logic [2:0] delay);
      aq_ctrl_t ctrl;
      word_t    rd;
      ctrl.enable = enable;
      ctrl.debug  = debug;
      ctrl.delay  = delay;
      bus_write(aq_adr(REG_AQ_CTRL), word_t'(ctrl));
      bus_read(aq_adr(REG_AQ_CTRL), rd);
      cmp_ctrl(aq_ctrl_t'(rd[$bits(aq_ctrl_t)-1:0]), ctrl);
   endtask

   task automatic pulse_strobe(input logic [ANTENNAE-1:0] value);
      @(negedge b_clk);
      antenna = value;
      ax_stb  = 1'b1;
      @(negedge b_clk);
      ax_stb  = 1'b0;
   endtask

   // Pops every modelled sample over the bus
   task automatic read_back_all();
      word_t rd;
      word_t want;
      while (exp_q.size() > 0) begin
         want = exp_q.pop_front();
         bus_read(aq_adr(REG_AQ_DATA), rd);
         cmp_byte("bus_rsp_o.dat (REG_AQ_DATA)", rd, want);
         exp_sum = exp_sum + want;              // Mod 256
      end
   endtask

   // ----------------------------------------
   // Tests
   // ----------------------------------------
   task automatic test_reset_state();
      word_t rd;
      bus_read(aq_adr(REG_AQ_STATUS), rd);
      cmp_status("REG_AQ_STATUS after reset", rd, 1'b0, 1'b0, 1'b1, 0);
      bus_read(aq_adr(REG_AQ_CTRL), rd);
      cmp_ctrl(aq_ctrl_t'(rd[$bits(aq_ctrl_t)-1:0]), '0);
   endtask

   task automatic test_capture_direct();
      logic [31:0] r;
      word_t       rd;
      set_ctrl(1'b1, 1'b0, 3'd0);
      for (int i = 0; i < 10; i++) begin
         r = lcg_next();
         pulse_strobe(r[23:16]);
         exp_q.push_back(BUS_BITS'(r[23:16]));
         dbg_next++;
      end
      bus_read(aq_adr(REG_AQ_STATUS), rd);
      cmp_status("REG_AQ_STATUS before read-back", rd, 1'b0, 1'b0, 1'b0, 10);
      read_back_all();
      bus_read(aq_adr(REG_AQ_SUM), rd);
      cmp_byte("REG_AQ_SUM", rd, exp_sum);
   endtask

   task automatic test_capture_delay();
      logic [31:0]         r;
      logic [ANTENNAE-1:0] hist [12];
      for (int d = 1; d < 8; d += 3) begin
         set_ctrl(1'b1, 1'b0, 3'(d));
         for (int k = 0; k < 12; k++) begin
            @(negedge b_clk);
            r       = lcg_next();
            hist[k] = r[31:24];
            antenna = hist[k];                  // New value every cycle
            ax_stb  = (k == 10);
         end
         @(negedge b_clk);
         ax_stb = 1'b0;
         exp_q.push_back(BUS_BITS'(hist[10-d]));
         dbg_next++;
         read_back_all();
      end
   endtask

   task automatic test_debug_overflow();
      logic [31:0] r;
      word_t       rd;
      set_ctrl(1'b1, 1'b1, 3'd0);
      for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
         r = lcg_next();
         pulse_strobe(r[15:8]);                 // Antenna ignored in debug mode
         if (i < FIFO_DEPTH) begin
            exp_q.push_back(dbg_next);
            dbg_next++;
         end
      end
      bus_read(aq_adr(REG_AQ_STATUS), rd);
      cmp_status("REG_AQ_STATUS when full", rd, 1'b0, 1'b1, 1'b0, FIFO_DEPTH);
      read_back_all();
   endtask

   task automatic test_underrun();
      word_t rd;
      bus_read(aq_adr(REG_AQ_DATA), rd);
      cmp_byte("bus_rsp_o.dat (REG_AQ_DATA empty)", rd, '0);
      bus_read(aq_adr(REG_AQ_STATUS), rd);
      cmp_status("REG_AQ_STATUS after underrun", rd, 1'b1, 1'b0, 1'b1, 0);
      bus_read(aq_adr(REG_AQ_STATUS), rd);
      cmp_status("REG_AQ_STATUS second read", rd, 1'b0, 1'b0, 1'b1, 0);
      bus_read(aq_adr(REG_AQ_SUM), rd);
      cmp_byte("REG_AQ_SUM", rd, exp_sum);
   endtask

   task automatic test_soft_reset();
      logic [31:0] r;
      word_t       rd;
      set_ctrl(1'b1, 1'b0, 3'd0);
      for (int i = 0; i < 3; i++) begin
         r = lcg_next();
         pulse_strobe(r[23:16]);
      end
      bus_read(rst_adr(REG_RST_STATUS), rd);
      cmp_status("REG_RST_STATUS before soft reset", rd, 1'b0, 1'b0, 1'b0, 3);
      bus_write(rst_adr(REG_RST), 8'h01);
      wait_reset_done();
      exp_q.delete();
      exp_sum  = '0;
      dbg_next = '0;
      bus_read(rst_adr(REG_RST_STATUS), rd);
      cmp_status("REG_RST_STATUS after soft reset", rd, 1'b0, 1'b0, 1'b1, 0);
      bus_read(aq_adr(REG_AQ_CTRL), rd);
      cmp_ctrl(aq_ctrl_t'(rd[$bits(aq_ctrl_t)-1:0]), '0);
      cmp_byte("led_o", {7'b0, led}, '0);
      bus_read(aq_adr(REG_AQ_SUM), rd);
      cmp_byte("REG_AQ_SUM after soft reset", rd, '0);
      // Debug ramp restarts from zero
      set_ctrl(1'b1, 1'b1, 3'd0);
      pulse_strobe('0);
      exp_q.push_back(dbg_next);
      read_back_all();
   endtask

   initial begin
      bus_req  = '0;
      antenna  = '0;
      ax_stb   = 1'b0;
      arst_n   = 1'b0;
      exp_sum  = '0;
      dbg_next = '0;
      repeat (5) @(negedge b_clk);
      arst_n = 1'b1;
      wait_reset_done();                        // Stretched reset after release
      test_reset_state();
      test_capture_direct();
      test_capture_delay();
      test_debug_overflow();
      test_underrun();
      test_soft_reset();
      if (dut_i.u_tart_assertions.fail_count == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         $display("Bound assertions failed");
         $display("Regression failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// File: tests/tart_assertions.sv
`default_nettype none
`timescale 1ns/1ns

module tart_assertions (
   input wire b_clk,
   input wire arst_n_i,
   input wire sys_rst_i,
   input wire full_i,
   input wire pop_i,
   input wire empty_i,
   input wire aq_stb_i,
   input wire aq_ack_i,
   input wire rst_stb_i,
   input wire rst_ack_i
);

   int fail_count = 0;                          // Assertion failures so far

   // ----------------------------------------
   // FIFO flow control
   // ----------------------------------------
   // A push taken while full would move the level off FIFO_DEPTH
   a_no_push_full: assert property (@(posedge b_clk) disable iff (!arst_n_i || sys_rst_i)
      full_i && !pop_i |=> full_i)
      else begin
         fail_count++;
         $error("FIFO accepted a push while full");
      end

   a_no_pop_empty: assert property (@(posedge b_clk) disable iff (!arst_n_i)
      pop_i |-> !empty_i)
      else begin
         fail_count++;
         $error("FIFO pop while empty");
      end

   // Ack one cycle after the first strobe cycle and no longer
   a_aq_ack_once: assert property (@(posedge b_clk) disable iff (!arst_n_i || sys_rst_i)
      $rose(aq_stb_i) |=> aq_ack_i ##1 !aq_ack_i)
      else begin
         fail_count++;
         $error("Acquisition ack not a single cycle after the strobe");
      end

   a_rst_ack_once: assert property (@(posedge b_clk) disable iff (!arst_n_i)
      $rose(rst_stb_i) |=> rst_ack_i ##1 !rst_ack_i)
      else begin
         fail_count++;
         $error("Reset controller ack not a single cycle after the strobe");
      end

endmodule

// Top level holds both the FIFO nets and the slave responses
bind tart_core tart_assertions u_tart_assertions (
   .b_clk     (b_clk),
   .arst_n_i  (arst_n_i),
   .sys_rst_i (sys_rst),
   .full_i    (full),
   .pop_i     (pop),
   .empty_i   (empty),
   .aq_stb_i  (aq_stb),
   .aq_ack_i  (aq_rsp.ack),
   .rst_stb_i (rst_stb),
   .rst_ack_i (rst_rsp.ack)
);

`default_nettype wire

// File: rtl/tart_core.sv
`default_nettype none
`timescale 1ns/1ns

module tart_core import tart_pkg::*; #(
   parameter int ANTENNAE   = 8,        // At most BUS_BITS
   parameter int FIFO_DEPTH = 16,
   parameter int RTIME      = 4         // Soft reset length
) (
   input  wire                b_clk,
   input  wire                arst_n_i,
   input  wire bus_req_t      bus_req_i,    // From the SPI slave on the board
   output bus_rsp_t           bus_rsp_o,
   input  wire [ANTENNAE-1:0] antenna_i,
   input  wire                ax_stb_i,
   output logic               led_o         // Acquisition running
);

   typedef logic [ANTENNAE-1:0] sample_t;

   // Bus fabric
   logic     aq_stb;
   logic     rst_stb;
   bus_rsp_t aq_rsp;
   bus_rsp_t rst_rsp;

   // ----------------------------------------
   // Data path and control
   // ----------------------------------------
   logic                               sys_rst;
   aq_ctrl_t                           aq_ctrl;
   logic                               push;
   sample_t                            sample;
   logic                               full;
   logic                               overflow;
   logic                               pop;
   sample_t                            head;
   logic                               empty;
   logic [$clog2(FIFO_DEPTH+1)-1:0]    level;
   word_t                              aq_status;

   assign led_o = aq_ctrl.enable;

   bus_decode u_bus_decode (
      .b_clk     (b_clk),
      .arst_n_i  (arst_n_i),
      .bus_req_i (bus_req_i),
      .aq_stb_o  (aq_stb),
      .rst_stb_o (rst_stb),
      .aq_rsp_i  (aq_rsp),
      .rst_rsp_i (rst_rsp),
      .bus_rsp_o (bus_rsp_o)
   );

   rst_control #(.RTIME(RTIME)) u_rst_control (
      .b_clk     (b_clk),
      .arst_n_i  (arst_n_i),
      .bus_req_i (bus_req_i),
      .stb_i     (rst_stb),
      .status_i  (aq_status),
      .rsp_o     (rst_rsp),
      .sys_rst_o (sys_rst)
   );

   // Producer
   ax_capture #(.ANTENNAE(ANTENNAE)) u_ax_capture (
      .b_clk      (b_clk),
      .arst_n_i   (arst_n_i),
      .sys_rst_i  (sys_rst),
      .ctrl_i     (aq_ctrl),
      .antenna_i  (antenna_i),
      .ax_stb_i   (ax_stb_i),
      .full_i     (full),
      .push_o     (push),
      .sample_o   (sample),
      .overflow_o (overflow)
   );

   // Buffer
   sample_fifo #(
      .payload_t  (sample_t),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_sample_fifo (
      .b_clk     (b_clk),
      .arst_n_i  (arst_n_i),
      .sys_rst_i (sys_rst),
      .push_i    (push),
      .data_i    (sample),
      .pop_i     (pop),
      .data_o    (head),
      .empty_o   (empty),
      .full_o    (full),
      .level_o   (level)
   );

   // Consumer
   aq_unit #(
      .ANTENNAE   (ANTENNAE),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_aq_unit (
      .b_clk      (b_clk),
      .arst_n_i   (arst_n_i),
      .sys_rst_i  (sys_rst),
      .bus_req_i  (bus_req_i),
      .stb_i      (aq_stb),
      .rsp_o      (aq_rsp),
      .ctrl_o     (aq_ctrl),
      .head_i     (head),
      .empty_i    (empty),
      .level_i    (level),
      .pop_o      (pop),
      .overflow_i (overflow),
      .status_o   (aq_status)
   );

endmodule

`default_nettype wire

// File: rtl/bus_decode.sv
`default_nettype none
`timescale 1ns/1ns

module bus_decode import tart_pkg::*; (
   input  wire           b_clk,
   input  wire           arst_n_i,
   input  wire bus_req_t bus_req_i,
   output logic          aq_stb_o,
   output logic          rst_stb_o,
   input  wire bus_rsp_t aq_rsp_i,
   input  wire bus_rsp_t rst_rsp_i,
   output bus_rsp_t      bus_rsp_o
);

   logic aq_sel;                        // Transfer in flight to acquisition unit
   logic rst_sel;                       // Transfer in flight to reset controller

   // ----------------------------------------
   // Strobe decode
   // ----------------------------------------
   assign aq_stb_o  = bus_req_i.stb && (bus_req_i.adr[ADR_BITS-1:3] == AQ_BASE);
   assign rst_stb_o = bus_req_i.stb && (bus_req_i.adr[ADR_BITS-1:2] == RST_BASE);

   // Select flags span strobe to ack, dropped early if cyc falls
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         aq_sel  <= 1'b0;
         rst_sel <= 1'b0;
      end else if (!bus_req_i.cyc) begin
         aq_sel  <= 1'b0;
         rst_sel <= 1'b0;
      end else begin
         aq_sel  <= (aq_sel || aq_stb_o) && !aq_rsp_i.ack;
         rst_sel <= (rst_sel || rst_stb_o) && !rst_rsp_i.ack;
      end
   end

   // ----------------------------------------
   // Response mux
   // ----------------------------------------
   always_comb begin
      bus_rsp_o.ack = aq_rsp_i.ack || rst_rsp_i.ack;   // Only one slave acks at a time
      if (rst_stb_o || rst_sel) begin
         bus_rsp_o.dat = rst_rsp_i.dat;
      end else if (aq_stb_o || aq_sel) begin
         bus_rsp_o.dat = aq_rsp_i.dat;
      end else begin
         bus_rsp_o.dat = '0;                           // Idle bus reads zero
      end
   end

endmodule

`default_nettype wire

// File: rtl/rst_control.sv
`default_nettype none
`timescale 1ns/1ns

module rst_control import tart_pkg::*; #(
   parameter int RTIME = 4              // Cycles of sys_rst
) (
   input  wire           b_clk,
   input  wire           arst_n_i,
   input  wire bus_req_t bus_req_i,
   input  wire           stb_i,
   input  wire word_t    status_i,      // Acquisition status byte
   output bus_rsp_t      rsp_o,
   output logic          sys_rst_o      // Sync, active high
);

   localparam int CW = $clog2(RTIME+1);

   logic [CW-1:0] rst_cnt;              // Remaining reset cycles
   logic          ack_q;
   word_t         dat_q;
   logic [1:0]    reg_adr;
   logic          access;
   logic          soft_rst;
   word_t         rd_dat;

   // ----------------------------------------
   // Register access
   // ----------------------------------------
   assign reg_adr = bus_req_i.adr[1:0];
   assign access  = stb_i && !ack_q;

   // Taken in the ack cycle, so sys_rst starts the cycle after ack
   assign soft_rst = stb_i && ack_q && bus_req_i.we
                     && (reg_adr == REG_RST) && bus_req_i.dat[0];

   always_comb begin
      case (reg_adr)
         REG_RST:        rd_dat = {{(BUS_BITS-1){1'b0}}, sys_rst_o};
         REG_RST_STATUS: rd_dat = status_i;
         default:        rd_dat = '0;
      endcase
   end

   always_ff @(posedge b_clk) begin
      if (access) begin
         dat_q <= rd_dat;
      end
   end

   // ----------------------------------------
   // Reset stretcher
   // ----------------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rst_cnt <= CW'(RTIME);                 // Held until RTIME edges after release
         ack_q   <= 1'b0;
      end else begin
         ack_q <= access;
         if (soft_rst) begin
            rst_cnt <= CW'(RTIME);
         end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;
         end
      end
   end

   assign sys_rst_o = (rst_cnt != '0);
   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = dat_q;

endmodule

`default_nettype wire

// File: rtl/aq_unit.sv
`default_nettype none
`timescale 1ns/1ns

module aq_unit import tart_pkg::*; #(
   parameter int ANTENNAE   = 8,
   parameter int FIFO_DEPTH = 16
) (
   input  wire                             b_clk,
   input  wire                             arst_n_i,
   input  wire                             sys_rst_i,
   input  wire bus_req_t                   bus_req_i,
   input  wire                             stb_i,      // Decoded strobe
   output bus_rsp_t                        rsp_o,
   output aq_ctrl_t                        ctrl_o,
   input  wire [ANTENNAE-1:0]              head_i,     // FIFO head sample
   input  wire                             empty_i,
   input  wire [$clog2(FIFO_DEPTH+1)-1:0]  level_i,
   output logic                            pop_o,
   input  wire                             overflow_i, // Pulse from capture
   output word_t                           status_o    // Non-clearing view
);

   aq_ctrl_t   ctrl_q;
   logic       ack_q;
   word_t      dat_q;
   word_t      sum_q;                           // Checksum of read-back bytes
   logic       underrun_q;
   logic       overflow_q;
   logic [2:0] reg_adr;
   logic       access;
   logic       rd_data;
   logic       rd_status;
   word_t      data_byte;
   word_t      rd_dat;

   // ----------------------------------------
   // Decode
   // ----------------------------------------
   assign reg_adr   = bus_req_i.adr[2:0];
   assign access    = stb_i && !ack_q;          // First cycle of the transfer
   assign rd_data   = access && !bus_req_i.we && (reg_adr == REG_AQ_DATA);
   assign rd_status = access && !bus_req_i.we && (reg_adr == REG_AQ_STATUS);

   assign data_byte = empty_i ? '0 : BUS_BITS'(head_i);  // Zero-extended head
   assign status_o  = {underrun_q, overflow_q, empty_i, 5'(level_i)};

   always_comb begin
      rd_dat = '0;
      case (reg_adr)
         REG_AQ_CTRL:   rd_dat[$bits(aq_ctrl_t)-1:0] = ctrl_q;
         REG_AQ_DATA:   rd_dat = data_byte;
         REG_AQ_STATUS: rd_dat = status_o;
         REG_AQ_SUM:    rd_dat = sum_q;
         default:       rd_dat = '0;            // Spare offsets read as zero
      endcase
   end

   // Read data is latched with ack, held through the ack cycle
   always_ff @(posedge b_clk) begin
      if (access) begin
         dat_q <= rd_dat;
      end
   end

   // ----------------------------------------
   // Control state
   // ----------------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q      <= 1'b0;
         pop_o      <= 1'b0;
         ctrl_q     <= '0;
         sum_q      <= '0;
         underrun_q <= 1'b0;
         overflow_q <= 1'b0;
      end else if (sys_rst_i) begin
         ack_q      <= 1'b0;
         pop_o      <= 1'b0;
         ctrl_q     <= '0;
         sum_q      <= '0;
         underrun_q <= 1'b0;
         overflow_q <= 1'b0;
      end else begin
         ack_q <= access;                       // Exactly one cycle
         pop_o <= rd_data && !empty_i;          // Head pops at end of ack cycle
         if (access && bus_req_i.we && (reg_adr == REG_AQ_CTRL)) begin
            ctrl_q <= aq_ctrl_t'(bus_req_i.dat[$bits(aq_ctrl_t)-1:0]);
         end
         if (rd_data) begin
            sum_q <= sum_q + data_byte;         // Wraps mod 256
         end
         // Sticky flags, a new event beats the clear
         underrun_q <= (underrun_q && !rd_status) || (rd_data && empty_i);
         overflow_q <= (overflow_q && !rd_status) || overflow_i;
      end
   end

   assign ctrl_o    = ctrl_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = dat_q;

endmodule

`default_nettype wire

// File: rtl/sample_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module sample_fifo #(
   parameter type payload_t  = logic [7:0],
   parameter int  FIFO_DEPTH = 16
) (
   input  wire                                b_clk,
   input  wire                                arst_n_i,
   input  wire                                sys_rst_i,
   input  wire                                push_i,
   input  wire payload_t                      data_i,
   input  wire                                pop_i,
   output payload_t                           data_o,    // Head, show-ahead
   output logic                               empty_o,
   output logic                               full_o,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]    level_o
);

   localparam int AW = $clog2(FIFO_DEPTH);      // Pointer width
   localparam int LW = $clog2(FIFO_DEPTH+1);    // Count width, holds FIFO_DEPTH

   payload_t      mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [LW-1:0] count;
   logic          do_push;
   logic          do_pop;

   // Wrap at FIFO_DEPTH, depth need not be a power of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
      return (p == AW'(FIFO_DEPTH-1)) ? '0 : p + 1'b1;
   endfunction

   // ----------------------------------------
   // Flags
   // ----------------------------------------
   assign empty_o = (count == '0);
   assign full_o  = (count == LW'(FIFO_DEPTH));
   assign level_o = count;

   assign do_push = push_i && !full_o;          // Guard, producer checks too
   assign do_pop  = pop_i && !empty_o;          // Pop on empty is ignored

   // ----------------------------------------
   // Storage
   // ----------------------------------------
   always_ff @(posedge b_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= data_i;
      end
   end

   assign data_o = mem[rd_ptr];                 // Valid when not empty

   // Pointers and count
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (sys_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/ax_capture.sv
`default_nettype none
`timescale 1ns/1ns

module ax_capture import tart_pkg::*; #(
   parameter int ANTENNAE = 8           // At most BUS_BITS
) (
   input  wire                 b_clk,
   input  wire                 arst_n_i,
   input  wire                 sys_rst_i,     // Sync, active high
   input  wire aq_ctrl_t       ctrl_i,
   input  wire [ANTENNAE-1:0]  antenna_i,
   input  wire                 ax_stb_i,      // One cycle per sample
   input  wire                 full_i,        // FIFO back-pressure
   output logic                push_o,
   output logic [ANTENNAE-1:0] sample_o,
   output logic                overflow_o     // Sample dropped
);

   logic [6:0][ANTENNAE-1:0] hist;              // hist[0] is last cycle's input
   logic [7:0][ANTENNAE-1:0] taps;              // taps[d] is input from d cycles back
   word_t                    dbg_cnt;
   logic                     strobe;

   // ----------------------------------------
   // Antenna delay line
   // ----------------------------------------
   always_ff @(posedge b_clk) begin
      hist <= {hist[5:0], antenna_i};           // Oldest entry falls off the top
   end

   // Tap 0 is the live input, so delay 0 needs no register
   assign taps = {hist, antenna_i};

   // ----------------------------------------
   // Sample select and push
   // ----------------------------------------
   assign strobe = ax_stb_i && ctrl_i.enable;

   always_comb begin
      if (ctrl_i.debug) begin
         sample_o = dbg_cnt[ANTENNAE-1:0];      // Known ramp for read-back tests
      end else begin
         sample_o = taps[ctrl_i.delay];
      end
   end

   assign push_o = strobe && !full_i;           // Written at the end of the strobe cycle

   // Debug counter and overflow pulse
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dbg_cnt    <= '0;
         overflow_o <= 1'b0;
      end else if (sys_rst_i) begin
         dbg_cnt    <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (push_o) begin
            dbg_cnt <= dbg_cnt + 1'b1;          // Counts accepted pushes only
         end
         overflow_o <= strobe && full_i;        // Lost sample, one cycle wide
      end
   end

endmodule

`default_nettype wire

// File: rtl/tart_pkg.sv
`default_nettype none

package tart_pkg;

   // ----------------------------------------
   // Bus geometry
   // ----------------------------------------
   localparam int BUS_BITS = 8;         // One byte per transfer
   localparam int ADR_BITS = 7;         // SPI command byte keeps 7 address bits

   // Bus byte, also the widest antenna sample
   typedef logic [BUS_BITS-1:0] word_t;

   // Master request, held until ack
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [ADR_BITS-1:0] adr;
      word_t               dat;         // Write data
   } bus_req_t;

   // Slave response
   typedef struct packed {
      logic  ack;                       // Single cycle
      word_t dat;                       // Valid with ack
   } bus_rsp_t;

   // Acquisition settings, as stored in REG_AQ_CTRL[4:0]
   typedef struct packed {
      logic       enable;
      logic       debug;                // Counter instead of antennae
      logic [2:0] delay;                // Taps back from the strobe cycle
   } aq_ctrl_t;

   // ----------------------------------------
   // Address map
   // ----------------------------------------
   localparam logic [3:0] AQ_BASE  = 4'h0;   // adr[6:3], 0x00 to 0x07
   localparam logic [4:0] RST_BASE = 5'h03;  // adr[6:2], 0x0C to 0x0F

   // Acquisition unit offsets
   localparam logic [2:0] REG_AQ_CTRL   = 3'd0;
   localparam logic [2:0] REG_AQ_DATA   = 3'd1;
   localparam logic [2:0] REG_AQ_STATUS = 3'd2;
   localparam logic [2:0] REG_AQ_SUM    = 3'd3;

   // Reset controller offsets
   localparam logic [1:0] REG_RST        = 2'd0;
   localparam logic [1:0] REG_RST_STATUS = 2'd1;

endpackage

`default_nettype wire
